// ==== rtl/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

        localparam int xlen   = 64;
        localparam int apb_aw = 8;
        localparam int apb_dw = 32;
        localparam int cnt_w  = 32;

        // rv64im register-register set, then the 32-bit w forms
        typedef enum logic [4:0] {
                op_add,
                op_sub,
                op_mul,
                op_div,
                op_divu,
                op_rem,
                op_remu,
                op_and,
                op_or,
                op_xor,
                op_sgeu,
                op_sltu,
                op_seq,
                op_sne,
                op_sge,
                op_slt,
                op_sll,
                op_sra,
                op_srl,
                op_addw,
                op_subw,
                op_sllw,
                op_sraw,
                op_srlw,
                op_mulw,
                op_divw,
                op_divuw,
                op_remw,
                op_remuw
        } alu_op_e;

        localparam int unsigned op_last = 28;

        // apb register map
        localparam logic [apb_aw-1:0] reg_ctrl   = 8'h00;
        localparam logic [apb_aw-1:0] reg_status = 8'h04;
        localparam logic [apb_aw-1:0] reg_a_lo   = 8'h08;
        localparam logic [apb_aw-1:0] reg_a_hi   = 8'h0C;
        localparam logic [apb_aw-1:0] reg_b_lo   = 8'h10;
        localparam logic [apb_aw-1:0] reg_b_hi   = 8'h14;
        localparam logic [apb_aw-1:0] reg_res_lo = 8'h18;
        localparam logic [apb_aw-1:0] reg_res_hi = 8'h1C;
        localparam logic [apb_aw-1:0] reg_count  = 8'h20;

        typedef struct packed {
                alu_op_e          op;
                logic [xlen-1:0]  a;
                logic [xlen-1:0]  b;
        } alu_req_t;

        typedef struct packed {
                logic [xlen-1:0]  result;
                logic             dz;
        } alu_rsp_t;

        typedef struct packed {
                logic             done;
                logic             dz_sticky;
                logic [cnt_w-1:0] count;
        } alu_stat_t;

endpackage

`default_nettype wire

// ==== rtl/rv_alu.sv ====
`default_nettype none
`timescale 1ns/10ps

module rv_alu (
        input  alu_pkg::alu_req_t req,
        output alu_pkg::alu_rsp_t rsp
);

        logic [alu_pkg::xlen-1:0]        a;
        logic [alu_pkg::xlen-1:0]        b;
        logic signed [alu_pkg::xlen-1:0] sa;
        logic signed [alu_pkg::xlen-1:0] sb;
        logic [31:0]                     aw;
        logic [31:0]                     bw;
        logic signed [31:0]              saw;
        logic signed [31:0]              sbw;
        logic signed [alu_pkg::xlen-1:0] div_s;
        logic signed [alu_pkg::xlen-1:0] rem_s;
        logic signed [31:0]              divw_s;
        logic signed [31:0]              remw_s;
        logic                            b_zero;
        logic                            bw_zero;
        logic                            ovf64;
        logic                            ovf32;
        logic                            div64;
        logic                            div32;
        logic [alu_pkg::xlen-1:0]        res;
        logic                            dz;

        function automatic logic [alu_pkg::xlen-1:0] sext_w(input logic [31:0] v);
                return {{(alu_pkg::xlen - 32){v[31]}}, v};
        endfunction

        assign a   = req.a;
        assign b   = req.b;
        assign sa  = req.a;
        assign sb  = req.b;
        assign aw  = req.a[31:0];
        assign bw  = req.b[31:0];
        assign saw = req.a[31:0];
        assign sbw = req.b[31:0];

        assign b_zero  = (b == '0);
        assign bw_zero = (bw == '0);

        // most negative divided by -1
        assign ovf64 = (a == {1'b1, {(alu_pkg::xlen - 1){1'b0}}}) && (b == '1);
        assign ovf32 = (aw == 32'h8000_0000) && (bw == '1);

        // signed quotients kept apart so their signedness is not lost in the muxes
        assign div_s  = sa / sb;
        assign rem_s  = sa % sb;
        assign divw_s = saw / sbw;
        assign remw_s = saw % sbw;

        assign div64 = req.op inside {alu_pkg::op_div, alu_pkg::op_divu,
                                      alu_pkg::op_rem, alu_pkg::op_remu};
        assign div32 = req.op inside {alu_pkg::op_divw, alu_pkg::op_divuw,
                                      alu_pkg::op_remw, alu_pkg::op_remuw};
        assign dz    = (div64 && b_zero) || (div32 && bw_zero);

        always_comb begin
                res = '0;
                case (req.op)
                        alu_pkg::op_add:   res = a + b;
                        alu_pkg::op_sub:   res = a - b;
                        alu_pkg::op_mul:   res = a * b;
                        alu_pkg::op_div:   res = b_zero ? '1 : ovf64 ? a : div_s;
                        alu_pkg::op_divu:  res = b_zero ? '1 : a / b;
                        alu_pkg::op_rem:   res = b_zero ? a : ovf64 ? '0 : rem_s;
                        alu_pkg::op_remu:  res = b_zero ? a : a % b;
                        alu_pkg::op_and:   res = a & b;
                        alu_pkg::op_or:    res = a | b;
                        alu_pkg::op_xor:   res = a ^ b;
                        alu_pkg::op_sgeu:  res = alu_pkg::xlen'(a >= b);
                        alu_pkg::op_sltu:  res = alu_pkg::xlen'(a < b);
                        alu_pkg::op_seq:   res = alu_pkg::xlen'(a == b);
                        alu_pkg::op_sne:   res = alu_pkg::xlen'(a != b);
                        alu_pkg::op_sge:   res = alu_pkg::xlen'(sa >= sb);
                        alu_pkg::op_slt:   res = alu_pkg::xlen'(sa < sb);
                        alu_pkg::op_sll:   res = a << b[5:0];
                        alu_pkg::op_sra:   res = sa >>> b[5:0];
                        alu_pkg::op_srl:   res = a >> b[5:0];
                        // w forms work on the low words and sign extend bit 31
                        alu_pkg::op_addw:  res = sext_w(aw + bw);
                        alu_pkg::op_subw:  res = sext_w(aw - bw);
                        alu_pkg::op_sllw:  res = sext_w(aw << b[4:0]);
                        alu_pkg::op_sraw:  res = sext_w(saw >>> b[4:0]);
                        alu_pkg::op_srlw:  res = sext_w(aw >> b[4:0]);
                        alu_pkg::op_mulw:  res = sext_w(aw * bw);
                        alu_pkg::op_divw:  res = sext_w(bw_zero ? '1 : ovf32 ? aw : divw_s);
                        alu_pkg::op_divuw: res = sext_w(bw_zero ? '1 : aw / bw);
                        alu_pkg::op_remw:  res = sext_w(bw_zero ? aw : ovf32 ? '0 : remw_s);
                        alu_pkg::op_remuw: res = sext_w(bw_zero ? aw : aw % bw);
                        default:           res = '0;
                endcase
        end

        assign rsp = '{result: res, dz: dz};

endmodule

`default_nettype wire

// ==== rtl/alu_exec.sv ====
`default_nettype none
`timescale 1ns/10ps

module alu_exec (
        input  logic               clk,
        input  logic               arst_n,
        input  logic               start,
        input  logic               dz_clr,
        input  alu_pkg::alu_rsp_t  rsp,
        output alu_pkg::alu_rsp_t  res,
        output alu_pkg::alu_stat_t stat
);

        // a new start simply overwrites the result
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        res <= '0;
                end else if (start) begin
                        res <= rsp;
                end
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        stat.done  <= 1'b0;
                        stat.count <= '0;
                end else if (start) begin
                        stat.done  <= 1'b1;
                        stat.count <= stat.count + 1'b1;
                end
        end

        // a dividing start in the same cycle as a clear keeps the flag set
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        stat.dz_sticky <= 1'b0;
                end else begin
                        stat.dz_sticky <= (stat.dz_sticky & ~dz_clr) | (start & rsp.dz);
                end
        end

        count_follows_start: assert property (
                @(posedge clk) disable iff (!arst_n)
                !start |=> $stable(stat.count)
        );

endmodule

`default_nettype wire

// ==== rtl/alu_regs.sv ====
`default_nettype none
`timescale 1ns/10ps

module alu_regs (
        input  logic                       clk,
        input  logic                       arst_n,
        input  logic                       psel,
        input  logic                       penable,
        input  logic                       pwrite,
        input  logic [alu_pkg::apb_aw-1:0] paddr,
        input  logic [alu_pkg::apb_dw-1:0] pwdata,
        output logic [alu_pkg::apb_dw-1:0] prdata,
        output logic                       pready,
        output logic                       pslverr,
        output alu_pkg::alu_req_t          req,
        output logic                       start,
        output logic                       dz_clr,
        input  alu_pkg::alu_rsp_t          res,
        input  alu_pkg::alu_stat_t         stat
);

        localparam int dw = alu_pkg::apb_dw;

        alu_pkg::alu_op_e          op_q;
        logic [alu_pkg::xlen-1:0]  a_q;
        logic [alu_pkg::xlen-1:0]  b_q;
        logic                      access;
        logic                      wr;
        logic                      ctrl_wr;
        logic                      op_ok;
        logic                      bad_start;
        logic                      mapped;

        // no wait states
        assign pready = 1'b1;

        assign access    = psel & penable;
        assign wr        = access & pwrite;
        assign ctrl_wr   = wr && (paddr == alu_pkg::reg_ctrl);
        assign op_ok     = (pwdata[4:0] <= 5'(alu_pkg::op_last));
        assign bad_start = ctrl_wr & pwdata[8] & ~op_ok;
        assign start     = ctrl_wr & pwdata[8] & op_ok;
        assign dz_clr    = wr && (paddr == alu_pkg::reg_status) && pwdata[1];

        assign mapped = paddr inside {alu_pkg::reg_ctrl, alu_pkg::reg_status,
                                      alu_pkg::reg_a_lo, alu_pkg::reg_a_hi,
                                      alu_pkg::reg_b_lo, alu_pkg::reg_b_hi,
                                      alu_pkg::reg_res_lo, alu_pkg::reg_res_hi,
                                      alu_pkg::reg_count};
        assign pslverr = access & (~mapped | bad_start);

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        op_q <= alu_pkg::op_add;
                end else if (ctrl_wr && !bad_start) begin
                        op_q <= alu_pkg::alu_op_e'(pwdata[4:0]);
                end
        end

        // operands
        always_ff @(posedge clk) begin
                if (wr) begin
                        case (paddr)
                                alu_pkg::reg_a_lo: a_q[dw-1:0]              <= pwdata;
                                alu_pkg::reg_a_hi: a_q[alu_pkg::xlen-1:dw] <= pwdata;
                                alu_pkg::reg_b_lo: b_q[dw-1:0]              <= pwdata;
                                alu_pkg::reg_b_hi: b_q[alu_pkg::xlen-1:dw] <= pwdata;
                                default: ;
                        endcase
                end
        end

        // the op being written goes straight to the alu on a start write
        assign req = '{op: start ? alu_pkg::alu_op_e'(pwdata[4:0]) : op_q,
                       a:  a_q,
                       b:  b_q};

        always_comb begin
                case (paddr)
                        alu_pkg::reg_ctrl:   prdata = {{(dw - 5){1'b0}}, op_q};
                        alu_pkg::reg_status: prdata = {{(dw - 2){1'b0}}, stat.dz_sticky,
                                                       stat.done};
                        alu_pkg::reg_a_lo:   prdata = a_q[dw-1:0];
                        alu_pkg::reg_a_hi:   prdata = a_q[alu_pkg::xlen-1:dw];
                        alu_pkg::reg_b_lo:   prdata = b_q[dw-1:0];
                        alu_pkg::reg_b_hi:   prdata = b_q[alu_pkg::xlen-1:dw];
                        alu_pkg::reg_res_lo: prdata = res.result[dw-1:0];
                        alu_pkg::reg_res_hi: prdata = res.result[alu_pkg::xlen-1:dw];
                        alu_pkg::reg_count:  prdata = stat.count;
                        default:             prdata = '0;
                endcase
        end

        start_one_cycle: assert property (
                @(posedge clk) disable iff (!arst_n)
                start |=> !start
        );

        dz_clr_one_cycle: assert property (
                @(posedge clk) disable iff (!arst_n)
                dz_clr |=> !dz_clr
        );

        penable_needs_psel: assert property (
                @(posedge clk) disable iff (!arst_n)
                penable |-> psel
        );

endmodule

`default_nettype wire

// ==== rtl/alu_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module alu_top (
        input  logic                       clk,
        input  logic                       arst_n,
        input  logic                       psel,
        input  logic                       penable,
        input  logic                       pwrite,
        input  logic [alu_pkg::apb_aw-1:0] paddr,
        input  logic [alu_pkg::apb_dw-1:0] pwdata,
        output logic [alu_pkg::apb_dw-1:0] prdata,
        output logic                       pready,
        output logic                       pslverr
);

        alu_pkg::alu_req_t  req;
        alu_pkg::alu_rsp_t  rsp;
        alu_pkg::alu_rsp_t  res;
        alu_pkg::alu_stat_t stat;
        logic               start;
        logic               dz_clr;

        alu_regs regs_i (
                .clk     (clk),
                .arst_n  (arst_n),
                .psel    (psel),
                .penable (penable),
                .pwrite  (pwrite),
                .paddr   (paddr),
                .pwdata  (pwdata),
                .prdata  (prdata),
                .pready  (pready),
                .pslverr (pslverr),
                .req     (req),
                .start   (start),
                .dz_clr  (dz_clr),
                .res     (res),
                .stat    (stat)
        );

        rv_alu alu_i (
                .req (req),
                .rsp (rsp)
        );

        alu_exec exec_i (
                .clk    (clk),
                .arst_n (arst_n),
                .start  (start),
                .dz_clr (dz_clr),
                .rsp    (rsp),
                .res    (res),
                .stat   (stat)
        );

endmodule

`default_nettype wire

// ==== include/alu_ref.svh ====
`ifndef alu_ref_svh
`define alu_ref_svh

// expected value of a 64-bit operation, straight from the rv64im rules
function automatic logic [63:0] ref64(input alu_pkg::alu_op_e op, input logic [63:0] a,
                                      input logic [63:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] q;
        logic signed [63:0] r;
        logic [63:0]        fill;
        logic               ovf;
        sa   = a;
        sb   = b;
        q    = sa / sb;
        r    = sa % sb;
        // bits shifted in from the top by an arithmetic right shift
        fill = {64{a[63]}} & ~({64{1'b1}} >> b[5:0]);
        ovf  = (a == 64'h8000_0000_0000_0000) && (b == 64'hffff_ffff_ffff_ffff);
        case (op)
                alu_pkg::op_add:  return a + b;
                alu_pkg::op_sub:  return a - b;
                alu_pkg::op_mul:  return a * b;
                alu_pkg::op_div:  return (b == 64'h0) ? 64'hffff_ffff_ffff_ffff : (ovf ? a : q);
                alu_pkg::op_divu: return (b == 64'h0) ? 64'hffff_ffff_ffff_ffff : a / b;
                alu_pkg::op_rem:  return (b == 64'h0) ? a : (ovf ? 64'h0 : r);
                alu_pkg::op_remu: return (b == 64'h0) ? a : a % b;
                alu_pkg::op_and:  return a & b;
                alu_pkg::op_or:   return a | b;
                alu_pkg::op_xor:  return a ^ b;
                alu_pkg::op_sgeu: return {63'h0, a >= b};
                alu_pkg::op_sltu: return {63'h0, a < b};
                alu_pkg::op_seq:  return {63'h0, a == b};
                alu_pkg::op_sne:  return {63'h0, a != b};
                alu_pkg::op_sge:  return {63'h0, sa >= sb};
                alu_pkg::op_slt:  return {63'h0, sa < sb};
                alu_pkg::op_sll:  return a << b[5:0];
                alu_pkg::op_sra:  return (a >> b[5:0]) | fill;
                alu_pkg::op_srl:  return a >> b[5:0];
                default:          return 64'h0;
        endcase
endfunction

// w forms run the 64-bit rules on extended low words, then sign extend bit 31
function automatic void alu_ref(input alu_pkg::alu_op_e op, input logic [63:0] a,
                                input logic [63:0] b, output logic [63:0] res,
                                output logic dz);
        logic [63:0] sa;
        logic [63:0] za;
        logic [63:0] sb;
        logic [63:0] zb;
        logic [63:0] r;
        sa = {{32{a[31]}}, a[31:0]};
        za = {32'h0, a[31:0]};
        sb = {{32{b[31]}}, b[31:0]};
        zb = {32'h0, b[31:0]};
        case (op)
                alu_pkg::op_addw:  r = ref64(alu_pkg::op_add, za, zb);
                alu_pkg::op_subw:  r = ref64(alu_pkg::op_sub, za, zb);
                alu_pkg::op_sllw:  r = ref64(alu_pkg::op_sll, za, zb & 64'h1f);
                alu_pkg::op_sraw:  r = ref64(alu_pkg::op_sra, sa, zb & 64'h1f);
                alu_pkg::op_srlw:  r = ref64(alu_pkg::op_srl, za, zb & 64'h1f);
                alu_pkg::op_mulw:  r = ref64(alu_pkg::op_mul, za, zb);
                alu_pkg::op_divw:  r = ref64(alu_pkg::op_div, sa, sb);
                alu_pkg::op_divuw: r = ref64(alu_pkg::op_divu, za, zb);
                alu_pkg::op_remw:  r = ref64(alu_pkg::op_rem, sa, sb);
                alu_pkg::op_remuw: r = ref64(alu_pkg::op_remu, za, zb);
                default:           r = ref64(op, a, b);
        endcase
        if (op >= alu_pkg::op_addw) begin
                res = {{32{r[31]}}, r[31:0]};
        end else begin
                res = r;
        end
        dz = ((op inside {alu_pkg::op_div, alu_pkg::op_divu, alu_pkg::op_rem,
                          alu_pkg::op_remu}) && (b == 64'h0)) ||
             ((op inside {alu_pkg::op_divw, alu_pkg::op_divuw, alu_pkg::op_remw,
                          alu_pkg::op_remuw}) && (zb == 64'h0));
endfunction

`endif

// ==== sim/alu_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module alu_tb;

        `include "alu_ref.svh"

        localparam int n_pairs  = 9;
        // clear, four operand writes, start, two result reads, status read
        localparam int n_xfer   = (alu_pkg::op_last + 1) * n_pairs * 9 + 40;
        localparam int limit_ns = n_xfer * 3 * 20 + 2000;

        logic                       clk;
        logic                       arst_n;
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [alu_pkg::apb_aw-1:0] paddr;
        logic [alu_pkg::apb_dw-1:0] pwdata;
        logic [alu_pkg::apb_dw-1:0] prdata;
        logic                       pready;
        logic                       pslverr;
        logic                       expect_err;
        logic [31:0]                rd_data;
        logic                       rd_err;
        logic [63:0]                res_exp;
        logic                       dz_exp;
        logic                       sticky_exp;
        int                         count_exp;
        integer                     seed;
        // 0, all ones, most negative, 0x80000000
        logic [63:0] edge_val [4] = '{64'h0, 64'hffff_ffff_ffff_ffff,
                                      64'h8000_0000_0000_0000, 64'h0000_0000_8000_0000};
        // selector 4 picks a random operand
        logic [2:0]  a_sel [n_pairs] = '{3'd4, 3'd4, 3'd0, 3'd1, 3'd4, 3'd2, 3'd3, 3'd4, 3'd4};
        logic [2:0]  b_sel [n_pairs] = '{3'd4, 3'd4, 3'd4, 3'd4, 3'd0, 3'd1, 3'd1, 3'd3, 3'd2};

        alu_top dut_i (.*);

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        task automatic value_error(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
                $display("ERROR %s expected 0x%08h actual 0x%08h", name, exp, act);
                $display("SOME TESTS FAILED");
                $fatal(1);
        endtask

        task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                                input logic err);
                @(posedge clk);
                psel       <= 1'b1;
                penable    <= 1'b0;
                pwrite     <= wr;
                paddr      <= addr;
                pwdata     <= data;
                expect_err <= err;
                @(posedge clk);
                penable <= 1'b1;
                @(negedge clk);
                while (!pready) @(negedge clk);
                rd_data = prdata;
                rd_err  = pslverr;
                @(posedge clk);
                psel       <= 1'b0;
                penable    <= 1'b0;
                expect_err <= 1'b0;
        endtask

        task automatic check_read(input logic [7:0] addr, input logic [31:0] exp,
                                  input string name);
                apb_xfer(1'b0, addr, 32'h0, 1'b0);
                assert (rd_data === exp) else value_error(name, exp, rd_data);
                assert (rd_err === 1'b0) else value_error("pslverr", 32'h0, 32'(rd_err));
        endtask

        function automatic logic [63:0] operand(input logic [2:0] sel);
                if (sel[2]) return {$random(seed), $random(seed)};
                return edge_val[sel[1:0]];
        endfunction

        task automatic run_op(input alu_pkg::alu_op_e op, input logic [63:0] a,
                              input logic [63:0] b);
                alu_ref(op, a, b, res_exp, dz_exp);
                apb_xfer(1'b1, alu_pkg::reg_a_lo, a[31:0], 1'b0);
                apb_xfer(1'b1, alu_pkg::reg_a_hi, a[63:32], 1'b0);
                apb_xfer(1'b1, alu_pkg::reg_b_lo, b[31:0], 1'b0);
                apb_xfer(1'b1, alu_pkg::reg_b_hi, b[63:32], 1'b0);
                apb_xfer(1'b1, alu_pkg::reg_ctrl, 32'h100 | 32'(op), 1'b0);
                count_exp++;
                sticky_exp = sticky_exp | dz_exp;
                check_read(alu_pkg::reg_res_lo, res_exp[31:0], "res_lo");
                check_read(alu_pkg::reg_res_hi, res_exp[63:32], "res_hi");
                check_read(alu_pkg::reg_status, {30'h0, sticky_exp, 1'b1}, "status");
        endtask

        // error response only in the access phase of a transfer meant to fail
        pslverr_check: assert property (
                @(posedge clk) disable iff (!arst_n)
                pslverr == (psel && penable && expect_err)
        ) else value_error("pslverr", 32'($sampled(psel && penable && expect_err)),
                           32'($sampled(pslverr)));

        // no wait states
        pready_check: assert property (
                @(posedge clk) disable iff (!arst_n)
                pready === 1'b1
        ) else value_error("pready", 32'h1, 32'($sampled(pready)));

        initial begin
                seed       = 32'h6934;
                arst_n     = 1'b0;
                psel       = 1'b0;
                penable    = 1'b0;
                pwrite     = 1'b0;
                paddr      = '0;
                pwdata     = '0;
                expect_err = 1'b0;
                sticky_exp = 1'b0;
                count_exp  = 0;
                repeat (2) @(posedge clk);
                arst_n <= 1'b1;
                check_read(alu_pkg::reg_status, 32'h0, "status");
                check_read(alu_pkg::reg_count, 32'h0, "count");
                for (int op = 0; op <= int'(alu_pkg::op_last); op++) begin
                        for (logic [3:0] k = 0; k < 4'(n_pairs); k++) begin
                                apb_xfer(1'b1, alu_pkg::reg_status, 32'h2, 1'b0);
                                sticky_exp = 1'b0;
                                run_op(alu_pkg::alu_op_e'(op), operand(a_sel[k]),
                                       operand(b_sel[k]));
                        end
                end
                // dz flag survives a later add and clears on a write of 1
                apb_xfer(1'b1, alu_pkg::reg_status, 32'h2, 1'b0);
                sticky_exp = 1'b0;
                run_op(alu_pkg::op_divu, 64'h1234, 64'h0);
                run_op(alu_pkg::op_add, 64'h1, 64'h2);
                apb_xfer(1'b1, alu_pkg::reg_status, 32'h2, 1'b0);
                check_read(alu_pkg::reg_status, 32'h1, "status");
                for (int op = alu_pkg::op_last + 1; op < 32; op++) begin
                        apb_xfer(1'b1, alu_pkg::reg_ctrl, 32'h100 | 32'(op), 1'b1);
                end
                check_read(alu_pkg::reg_res_lo, res_exp[31:0], "res_lo");
                check_read(alu_pkg::reg_res_hi, res_exp[63:32], "res_hi");
                check_read(alu_pkg::reg_status, 32'h1, "status");
                check_read(alu_pkg::reg_count, count_exp, "count");
                // unmapped offset
                apb_xfer(1'b1, 8'h24, 32'hdead_beef, 1'b1);
                apb_xfer(1'b0, 8'h24, 32'h0, 1'b1);
                assert (rd_data === 32'h0) else value_error("prdata", 32'h0, rd_data);
                assert (rd_err === 1'b1) else value_error("pslverr", 32'h1, 32'(rd_err));
                $display("ALL TESTS PASSED");
                $finish;
        end

        initial begin
                #(limit_ns);
                $display("timeout, the APB sequence did not complete in the expected time");
                $display("SOME TESTS FAILED");
                $fatal(1);
        end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
rtl/alu_pkg.sv
rtl/rv_alu.sv
rtl/alu_exec.sv
rtl/alu_regs.sv
rtl/alu_top.sv
sim/alu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= alu_tb
RTL_TOP   ?= alu_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= SOME TESTS FAILED
PASS_MSG  ?= ALL TESTS PASSED

BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation incomplete, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
